/* Makefile */
SRCS := $(wildcard hdl/*.sv testbench/*.sv)

all: run

obj_dir/Vmap_193_tb: map_193_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 -f map_193_top.f --top-module map_193_tb

run: obj_dir/Vmap_193_tb
	obj_dir/Vmap_193_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "SOME TESTS FAILED" sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* hdl/map_193_top.sv */
`timescale 1ns/1ps

module map_193_top
(
	input  logic                  m2,	// CPU phase clock
	input  logic                  rst_n,

	// cpu bus
	input  mapper_pkg::cpu_addr_t cpu_addr,
	input  mapper_pkg::bus_data_t cpu_dat,
	input  logic                  cpu_rw,
	input  logic                  cpu_ce,

	// ppu bus
	input  mapper_pkg::ppu_addr_t ppu_addr,
	input  logic                  ppu_oe,
	input  logic                  ppu_we,

	input  logic                  cfg_chr_ram,

	// save-state controller
	input  logic                  ss_act,
	input  logic                  ss_we,
	input  mapper_pkg::ss_addr_t  ss_addr,
	output mapper_pkg::bus_data_t ss_rdat,

	// memory side
	output mapper_pkg::prg_addr_t prg_addr,
	output mapper_pkg::chr_addr_t chr_addr,
	output logic                  rom_ce,
	output logic                  prg_oe,
	output logic                  chr_ce,
	output logic                  chr_oe,
	output logic                  chr_we,
	output logic                  ram_ce,
	output logic                  ram_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce
);

	mapper_pkg::prg_bank_t prg;
	mapper_pkg::bus_data_t chr0;
	mapper_pkg::bus_data_t chr1;
	mapper_pkg::bus_data_t chr2;

	// --------------------
	// bank registers

	map_bank_regs map_bank_regs_i
	(
		.m2       (m2),
		.rst_n    (rst_n),
		.cpu_addr (cpu_addr),
		.cpu_dat  (cpu_dat),
		.cpu_rw   (cpu_rw),
		.cpu_ce   (cpu_ce),
		.ss_act   (ss_act),
		.ss_we    (ss_we),
		.ss_addr  (ss_addr),
		.prg      (prg),
		.chr0     (chr0),
		.chr1     (chr1),
		.chr2     (chr2),
		.ss_rdat  (ss_rdat)
	);

	// --------------------
	// decode

	map_addr_xlat map_addr_xlat_i
	(
		.cpu_addr (cpu_addr),
		.ppu_addr (ppu_addr),
		.prg      (prg),
		.chr0     (chr0),
		.chr1     (chr1),
		.chr2     (chr2),
		.prg_addr (prg_addr),
		.chr_addr (chr_addr)
	);

	map_chip_sel map_chip_sel_i
	(
		.cpu_rw      (cpu_rw),
		.cpu_ce      (cpu_ce),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.rom_ce      (rom_ce),
		.prg_oe      (prg_oe),
		.chr_ce      (chr_ce),
		.chr_oe      (chr_oe),
		.chr_we      (chr_we),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

endmodule

/* hdl/map_addr_xlat.sv */
`timescale 1ns/1ps

module map_addr_xlat
(
	input  mapper_pkg::cpu_addr_t cpu_addr,
	input  mapper_pkg::ppu_addr_t ppu_addr,

	input  mapper_pkg::prg_bank_t prg,
	input  mapper_pkg::bus_data_t chr0,
	input  mapper_pkg::bus_data_t chr1,
	input  mapper_pkg::bus_data_t chr2,

	output mapper_pkg::prg_addr_t prg_addr,
	output mapper_pkg::chr_addr_t chr_addr
);

	logic [1:0] prg_region;	// 8 KB region inside the ROM space
	logic [3:0] prg_bank;
	logic [6:0] chr_bank;	// in 2 KB units
	logic       chr_hi_half;
	logic       chr_hi_quarter;

	// --------------------
	// PRG

	assign prg_region = cpu_addr[14:13];

	always_comb
	begin
		if (prg_region == 2'd0)
		begin
			prg_bank = prg;	// $8000-$9FFF switchable
		end
		else
		begin
			prg_bank = {mapper_pkg::PRG_FIXED_HI, prg_region};	// banks 13..15
		end
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};

	// --------------------
	// CHR

	assign chr_hi_half    = ppu_addr[12];
	assign chr_hi_quarter = ppu_addr[11];

	// lower pattern table is one 4 KB bank, upper one is two 2 KB banks
	always_comb
	begin
		if (!chr_hi_half)
		begin
			chr_bank = {chr0[7:2], chr_hi_quarter};	// chr0 counts 1 KB, bit 1:0 ignored
		end
		else if (!chr_hi_quarter)
		begin
			chr_bank = chr1[7:1];
		end
		else
		begin
			chr_bank = chr2[7:1];
		end
	end

	assign chr_addr = {chr_bank, ppu_addr[10:0]};

endmodule

/* hdl/map_bank_regs.sv */
`timescale 1ns/1ps

module map_bank_regs
(
	input  logic                  m2,
	input  logic                  rst_n,

	input  mapper_pkg::cpu_addr_t cpu_addr,
	input  mapper_pkg::bus_data_t cpu_dat,
	input  logic                  cpu_rw,	// 1 = read
	input  logic                  cpu_ce,	// ROM select, active low

	input  logic                  ss_act,
	input  logic                  ss_we,
	input  mapper_pkg::ss_addr_t  ss_addr,

	output mapper_pkg::prg_bank_t prg,
	output mapper_pkg::bus_data_t chr0,
	output mapper_pkg::bus_data_t chr1,
	output mapper_pkg::bus_data_t chr2,
	output mapper_pkg::bus_data_t ss_rdat
);

	logic       win_hit;	// cpu access inside the register window
	logic       win_wr;
	logic [1:0] reg_sel;
	logic       prg_ld;
	logic       chr0_ld;
	logic       chr1_ld;
	logic       chr2_ld;

	// --------------------
	// write decode

	// the window is only seen when ROM is not selected
	assign win_hit = cpu_ce && (cpu_addr[14:13] == mapper_pkg::REG_WINDOW);
	assign win_wr  = win_hit && !cpu_rw;
	assign reg_sel = cpu_addr[1:0];

	// save-state port wins while it is active
	always_comb
	begin
		if (ss_act)
		begin
			prg_ld  = ss_we && (ss_addr == mapper_pkg::SS_PRG);
			chr0_ld = ss_we && (ss_addr == mapper_pkg::SS_CHR0);
			chr1_ld = ss_we && (ss_addr == mapper_pkg::SS_CHR1);
			chr2_ld = ss_we && (ss_addr == mapper_pkg::SS_CHR2);
		end
		else
		begin
			chr0_ld = win_wr && (reg_sel == 2'd0);
			chr1_ld = win_wr && (reg_sel == 2'd1);
			chr2_ld = win_wr && (reg_sel == 2'd2);
			prg_ld  = win_wr && (reg_sel == 2'd3);
		end
	end

	// --------------------
	// bank registers

	always_ff @(posedge m2 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prg  <= '0;
			chr0 <= '0;
			chr1 <= '0;
			chr2 <= '0;
		end
		else
		begin
			if (prg_ld)
			begin
				prg <= cpu_dat[mapper_pkg::PRG_BANK_W-1:0];	// upper nibble dropped
			end
			if (chr0_ld)
			begin
				chr0 <= cpu_dat;
			end
			if (chr1_ld)
			begin
				chr1 <= cpu_dat;
			end
			if (chr2_ld)
			begin
				chr2 <= cpu_dat;
			end
		end
	end

	// --------------------
	// save-state readback

	always_comb
	begin
		case (ss_addr)
			mapper_pkg::SS_PRG:
			begin
				ss_rdat = {{(mapper_pkg::BUS_DATA_W - mapper_pkg::PRG_BANK_W){1'b0}}, prg};
			end
			mapper_pkg::SS_CHR0:    ss_rdat = chr0;
			mapper_pkg::SS_CHR1:    ss_rdat = chr1;
			mapper_pkg::SS_CHR2:    ss_rdat = chr2;
			mapper_pkg::SS_MAP_IDX: ss_rdat = mapper_pkg::MAP_IDX;
			default:                ss_rdat = mapper_pkg::SS_EMPTY;
		endcase
	end

endmodule

/* hdl/map_chip_sel.sv */
`timescale 1ns/1ps

module map_chip_sel
(
	input  logic                  cpu_rw,	// 1 = read
	input  logic                  cpu_ce,	// ROM select, active low

	input  mapper_pkg::ppu_addr_t ppu_addr,
	input  logic                  ppu_oe,	// active low
	input  logic                  ppu_we,	// active low

	input  logic                  cfg_chr_ram,

	output logic                  rom_ce,
	output logic                  prg_oe,
	output logic                  chr_ce,
	output logic                  chr_oe,
	output logic                  chr_we,
	output logic                  ram_ce,
	output logic                  ram_we,
	output logic                  ciram_a10,
	output logic                  ciram_ce
);

	// --------------------
	// CPU side

	assign rom_ce = !cpu_ce;
	assign prg_oe = cpu_rw;

	// board has no work RAM
	assign ram_ce = 1'b0;
	assign ram_we = 1'b0;

	// --------------------
	// PPU side

	// CIRAM and CHR share the pattern space decode, A13 low
	assign ciram_ce = !ppu_addr[13];
	assign chr_ce   = ciram_ce;
	assign chr_oe   = !ppu_oe;

	// writes only reach CHR when it is RAM
	assign chr_we = cfg_chr_ram && !ppu_we && ciram_ce;

	// hardwired mirroring on A10
	assign ciram_a10 = ppu_addr[10];

endmodule

/* hdl/mapper_pkg.sv */
package mapper_pkg;

	// --------------------
	// bus widths

	localparam int CPU_ADDR_W = 15;	// A15 arrives as cpu_ce
	localparam int PPU_ADDR_W = 14;
	localparam int BUS_DATA_W = 8;
	localparam int PRG_ADDR_W = 17;	// 128 KB of PRG ROM
	localparam int CHR_ADDR_W = 18;	// 256 KB of CHR memory
	localparam int SS_ADDR_W  = 8;
	localparam int PRG_BANK_W = 4;	// 16 banks of 8 KB

	typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
	typedef logic [PPU_ADDR_W-1:0] ppu_addr_t;
	typedef logic [BUS_DATA_W-1:0] bus_data_t;
	typedef logic [PRG_ADDR_W-1:0] prg_addr_t;
	typedef logic [CHR_ADDR_W-1:0] chr_addr_t;
	typedef logic [SS_ADDR_W-1:0]  ss_addr_t;
	typedef logic [PRG_BANK_W-1:0] prg_bank_t;

	// --------------------
	// mapper identity and register window

	localparam bus_data_t MAP_IDX = 8'hC1;	// board 193

	// A14:13 value of the bank register window, $6000-$7FFF
	localparam logic [1:0] REG_WINDOW = 2'b11;

	// --------------------
	// save-state indices

	localparam ss_addr_t SS_PRG     = 8'd0;
	localparam ss_addr_t SS_CHR0    = 8'd1;
	localparam ss_addr_t SS_CHR1    = 8'd2;
	localparam ss_addr_t SS_CHR2    = 8'd3;
	localparam ss_addr_t SS_MAP_IDX = 8'd127;	// mapper number readback

	localparam bus_data_t SS_EMPTY = 8'hFF;	// unused slots read as all ones

	// --------------------
	// PRG layout

	// $A000-$FFFF sit at the top of ROM, banks 13..15
	localparam logic [1:0] PRG_FIXED_HI = 2'b11;

endpackage

/* map_193_top.f */
hdl/mapper_pkg.sv
hdl/map_bank_regs.sv
hdl/map_addr_xlat.sv
hdl/map_chip_sel.sv
hdl/map_193_top.sv
testbench/tb_clock.sv
testbench/map_193_sva.sv
testbench/map_193_tb.sv

/* testbench/map_193_sva.sv */
`timescale 1ns/1ps

module map_193_sva
(
	input logic                  m2,
	input logic                  rst_n,
	input mapper_pkg::cpu_addr_t cpu_addr,
	input logic                  cpu_rw,
	input logic                  cpu_ce,
	input logic                  ss_act,
	input logic                  ss_we,
	input mapper_pkg::prg_bank_t prg,
	input mapper_pkg::bus_data_t chr0,
	input mapper_pkg::bus_data_t chr1,
	input mapper_pkg::bus_data_t chr2,
	input logic                  cfg_chr_ram,
	input logic                  chr_we,
	input logic                  ram_ce,
	input logic                  ram_we
);

	int unsigned fail_cnt = 0;	// read by the testbench at the end
	logic        bank_wr;

	// any access that is allowed to load a bank register
	assign bank_wr = (ss_act && ss_we) ||
		(!ss_act && cpu_ce && !cpu_rw && (cpu_addr[14:13] == mapper_pkg::REG_WINDOW));

	// --------------------
	// register window

	bank_hold: assert property (@(posedge m2) disable iff (!rst_n)
		({prg, chr0, chr1, chr2} != $past({prg, chr0, chr1, chr2})) |-> $past(bank_wr))
	else
	begin
		fail_cnt++;
		$error("bank register changed without a window or save-state write");
	end

	// --------------------
	// chip selects

	no_work_ram: assert property (@(posedge m2) disable iff (!rst_n) !ram_ce && !ram_we)
	else
	begin
		fail_cnt++;
		$error("work RAM enabled on a board without work RAM");
	end

	chr_we_gated: assert property (@(posedge m2) disable iff (!rst_n) chr_we |-> cfg_chr_ram)
	else
	begin
		fail_cnt++;
		$error("CHR write enable active while CHR is ROM");
	end

endmodule

bind map_193_top map_193_sva map_193_sva_i
(
	.m2          (m2),
	.rst_n       (rst_n),
	.cpu_addr    (cpu_addr),
	.cpu_rw      (cpu_rw),
	.cpu_ce      (cpu_ce),
	.ss_act      (ss_act),
	.ss_we       (ss_we),
	.prg         (prg),
	.chr0        (chr0),
	.chr1        (chr1),
	.chr2        (chr2),
	.cfg_chr_ram (cfg_chr_ram),
	.chr_we      (chr_we),
	.ram_ce      (ram_ce),
	.ram_we      (ram_we)
);

/* testbench/map_193_tb.sv */
`timescale 1ns/1ps

module map_193_tb;

	localparam int unsigned SEED = 32'had8cb794;
	localparam int N_RESET = 16;	// cycles per behavior
	localparam int N_CPU   = 400;
	localparam int N_PPU   = 300;
	localparam int N_SS    = 200;
	localparam int N_SEL   = 300;
	localparam int WATCHDOG_NS = 2 * 100 * (4 + N_RESET + N_CPU + N_PPU + N_SS + N_SEL + 8);

	typedef struct packed
	{
		mapper_pkg::prg_addr_t prg_addr;
		mapper_pkg::chr_addr_t chr_addr;
		mapper_pkg::bus_data_t ss_rdat;
		logic rom_ce;
		logic prg_oe;
		logic chr_ce;
		logic chr_oe;
		logic chr_we;
		logic ram_ce;
		logic ram_we;
		logic ciram_a10;
		logic ciram_ce;
	} expected_t;

	logic                  m2;
	logic                  rst_n;
	mapper_pkg::cpu_addr_t cpu_addr;
	mapper_pkg::bus_data_t cpu_dat;
	logic                  cpu_rw;
	logic                  cpu_ce;
	mapper_pkg::ppu_addr_t ppu_addr;
	logic                  ppu_oe;
	logic                  ppu_we;
	logic                  cfg_chr_ram;
	logic                  ss_act;
	logic                  ss_we;
	mapper_pkg::ss_addr_t  ss_addr;
	mapper_pkg::bus_data_t ss_rdat;
	mapper_pkg::prg_addr_t prg_addr;
	mapper_pkg::chr_addr_t chr_addr;
	logic                  rom_ce;
	logic                  prg_oe;
	logic                  chr_ce;
	logic                  chr_oe;
	logic                  chr_we;
	logic                  ram_ce;
	logic                  ram_we;
	logic                  ciram_a10;
	logic                  ciram_ce;

	mapper_pkg::prg_bank_t sh_prg;	// shadow copy of the bank registers
	mapper_pkg::bus_data_t sh_chr0;
	mapper_pkg::bus_data_t sh_chr1;
	mapper_pkg::bus_data_t sh_chr2;

	tb_clock tb_clock_i (.m2(m2), .rst_n(rst_n));

	map_193_top map_193_top_i (.*);

	// --------------------
	// reference model

	function automatic expected_t model_outputs();
		expected_t             e;
		logic [3:0]            bank;
		mapper_pkg::bus_data_t sel;
		if (cpu_addr[14:13] == 2'd0)
			bank = sh_prg;
		else
			bank = 4'd12 + {2'b00, cpu_addr[14:13]};	// $A000 -> 13, $C000 -> 14, $E000 -> 15
		e.prg_addr = {bank, cpu_addr[12:0]};
		sel = ppu_addr[11] ? sh_chr2 : sh_chr1;
		if (!ppu_addr[12])
			e.chr_addr = {sh_chr0 & 8'hFC, 10'd0} + {6'd0, ppu_addr[11:0]};	// 4 KB bank
		else
			e.chr_addr = {sel & 8'hFE, 10'd0} + {7'd0, ppu_addr[10:0]};	// 2 KB banks
		case (ss_addr)
			8'd0:    e.ss_rdat = {4'h0, sh_prg};
			8'd1:    e.ss_rdat = sh_chr0;
			8'd2:    e.ss_rdat = sh_chr1;
			8'd3:    e.ss_rdat = sh_chr2;
			8'd127:  e.ss_rdat = mapper_pkg::MAP_IDX;
			default: e.ss_rdat = 8'hFF;
		endcase
		e.rom_ce    = (cpu_ce == 1'b0);
		e.prg_oe    = cpu_rw;
		e.ciram_ce  = (ppu_addr < 14'h2000);	// pattern space
		e.chr_ce    = e.ciram_ce;
		e.chr_oe    = (ppu_oe == 1'b0);
		e.chr_we    = cfg_chr_ram && (ppu_we == 1'b0) && e.ciram_ce;
		e.ram_ce    = 1'b0;
		e.ram_we    = 1'b0;
		e.ciram_a10 = ppu_addr[10];
		return e;
	endfunction

	task automatic update_shadow();
		if (ss_act)
		begin
			if (ss_we)
			begin
				case (ss_addr)
					8'd0:    sh_prg  = cpu_dat[3:0];
					8'd1:    sh_chr0 = cpu_dat;
					8'd2:    sh_chr1 = cpu_dat;
					8'd3:    sh_chr2 = cpu_dat;
					default: ;
				endcase
			end
		end
		else if (cpu_ce && !cpu_rw && (cpu_addr[14:13] == 2'b11))
		begin
			case (cpu_addr[1:0])
				2'd0: sh_chr0 = cpu_dat;
				2'd1: sh_chr1 = cpu_dat;
				2'd2: sh_chr2 = cpu_dat;
				2'd3: sh_prg  = cpu_dat[3:0];
			endcase
		end
	endtask

	// --------------------
	// comparison

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "output check failed");
		end
	endtask

	task automatic check_outputs();
		expected_t e;
		e = model_outputs();
		compare_value("prg_addr", prg_addr, e.prg_addr);
		compare_value("chr_addr", chr_addr, e.chr_addr);
		compare_value("ss_rdat", ss_rdat, e.ss_rdat);
		compare_value("rom_ce", rom_ce, e.rom_ce);
		compare_value("prg_oe", prg_oe, e.prg_oe);
		compare_value("chr_ce", chr_ce, e.chr_ce);
		compare_value("chr_oe", chr_oe, e.chr_oe);
		compare_value("chr_we", chr_we, e.chr_we);
		compare_value("ram_ce", ram_ce, e.ram_ce);
		compare_value("ram_we", ram_we, e.ram_we);
		compare_value("ciram_a10", ciram_a10, e.ciram_a10);
		compare_value("ciram_ce", ciram_ce, e.ciram_ce);
	endtask

	// inputs only move on the rising edge, so mid-cycle is settled
	always @(negedge m2)
	begin
		if (rst_n !== 1'b1)
		begin
			sh_prg  = '0;
			sh_chr0 = '0;
			sh_chr1 = '0;
			sh_chr2 = '0;
		end
		else
		begin
			check_outputs();
			update_shadow();	// takes effect on the next rising edge
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// --------------------
	// stimulus

	initial
	begin
		logic [31:0] r;
		cpu_addr    <= '0;
		cpu_dat     <= '0;
		cpu_rw      <= 1'b1;
		cpu_ce      <= 1'b0;
		ppu_addr    <= '0;
		ppu_oe      <= 1'b1;
		ppu_we      <= 1'b1;
		cfg_chr_ram <= 1'b0;
		ss_act      <= 1'b0;
		ss_we       <= 1'b0;
		ss_addr     <= '0;
		void'($urandom(SEED));
		wait (rst_n === 1'b1);

		for (int i = 0; i < N_RESET; i++)	// reset banks visible
		begin
			r = $urandom();
			@(posedge m2);
			cpu_addr <= {2'b00, r[12:0]};
			ppu_addr <= r[29:16];
		end

		for (int i = 0; i < N_CPU; i++)	// window writes, reads and stray writes
		begin
			r = $urandom();
			@(posedge m2);
			cpu_addr <= r[31] ? {2'b11, r[12:0]} : r[14:0];
			cpu_dat  <= r[22:15];
			cpu_rw   <= r[23] & r[24];
			cpu_ce   <= r[25] | r[26];
		end

		for (int i = 0; i < N_PPU; i++)	// CHR banks under moving registers
		begin
			r = $urandom();
			@(posedge m2);
			ppu_addr <= r[13:0];
			cpu_addr <= {2'b11, 11'd0, r[15:14]};
			cpu_dat  <= r[23:16];
			cpu_rw   <= r[24] | r[25] | r[26];
			cpu_ce   <= 1'b1;
		end

		for (int i = 0; i < N_SS; i++)	// save-state port owns the registers
		begin
			r = $urandom();
			@(posedge m2);
			ss_act   <= 1'b1;
			ss_we    <= r[0];
			if (!r[3])
				ss_addr <= {6'd0, r[2:1]};
			else if (r[2:1] == 2'd0)
				ss_addr <= 8'd127;
			else
				ss_addr <= r[15:8];
			cpu_addr <= {2'b11, 11'd0, r[17:16]};
			cpu_dat  <= r[25:18];
			cpu_rw   <= 1'b0;	// window writes to be ignored
			cpu_ce   <= 1'b1;
			ppu_addr <= r[31:18];
		end
		@(posedge m2);
		ss_act <= 1'b0;
		ss_we  <= 1'b0;
		cpu_rw <= 1'b1;

		for (int i = 0; i < N_SEL; i++)	// decode, CHR RAM enabled in second half
		begin
			r = $urandom();
			@(posedge m2);
			cfg_chr_ram <= (i >= N_SEL / 2) && r[0];
			ppu_addr    <= r[14:1];
			ppu_oe      <= r[15];
			ppu_we      <= r[16];
			cpu_rw      <= r[17];
			cpu_ce      <= r[18];
			cpu_addr    <= r[31:17];
			cpu_dat     <= r[26:19];
		end
		@(posedge m2);
		cpu_rw <= 1'b1;
		repeat (2) @(posedge m2);

		if (map_193_top_i.map_193_sva_i.fail_cnt == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("%0d bound assertion failures", map_193_top_i.map_193_sva_i.fail_cnt);
			$display("SOME TESTS FAILED");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock
(
	output logic m2,
	output logic rst_n
);

	localparam int HALF_PERIOD = 50;	// 100 ns m2 period
	localparam int RST_CYCLES  = 4;

	initial
	begin
		m2 = 1'b0;
		forever #(HALF_PERIOD) m2 = ~m2;
	end

	initial
	begin
		rst_n <= 1'b0;
		repeat (RST_CYCLES) @(posedge m2);
		rst_n <= 1'b1;	// released on a rising edge
	end

endmodule
